//--- src/cluster_consts.svh
`ifndef CLUSTER_CONSTS_SVH
`define CLUSTER_CONSTS_SVH

`define CLUSTER_XLEN      32
`define CLUSTER_LANES     4
`define CLUSTER_LANE_BITS 2                // log2 of the lane count.

`define OP_RTYPE  7'b0110011              // register-register ops.
`define OP_IMM    7'b0010011              // register-immediate ops.
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

`endif

//--- src/rvIsaPkg.sv
package rvIsaPkg;

    // raw instruction word as fetched.
    typedef logic [31:0] instrT;

    // instr[6:0].
    typedef logic [6:0] opcodeT;

    // instr[14:12].
    typedef logic [2:0] funct3T;

    // branch conditions carried in funct3.
    localparam funct3T F3_BEQ  = 3'b000;
    localparam funct3T F3_BNE  = 3'b001;
    localparam funct3T F3_BLT  = 3'b100;
    localparam funct3T F3_BGE  = 3'b101;
    localparam funct3T F3_BLTU = 3'b110;
    localparam funct3T F3_BGEU = 3'b111;

endpackage

//--- src/aluExecPkg.sv
`include "cluster_consts.svh"

package aluExecPkg;

    typedef logic [`CLUSTER_XLEN-1:0]      wordT;
    typedef logic [`CLUSTER_LANE_BITS-1:0] laneIdT;

    // ALU function select, ADD must stay at zero.
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        SGE  = 4'd10,
        SGEU = 4'd11
    } aluSelT;

    typedef enum logic [1:0] {IDLE, ACKING, RELEASE} dispStateT;

    typedef enum logic [1:0] {WAIT, OFFER, RETIRE} collStateT;

endpackage

//--- src/aluControl.sv
`timescale 1ns/1ps
`include "cluster_consts.svh"

module aluControl (
    input  rvIsaPkg::opcodeT   opcode,
    input  rvIsaPkg::funct3T   funct3,
    input  logic               bit30,
    output aluExecPkg::aluSelT aluSel
);
    import rvIsaPkg::*;
    import aluExecPkg::*;

    aluSelT arithSel;                      // mapping shared by R-type and OP-IMM.
    aluSelT branchSel;

    always_comb begin
        case (funct3)
            3'b000: arithSel = bit30 ? SUB : ADD;
            3'b001: arithSel = SLL;
            3'b010: arithSel = SLT;
            3'b011: arithSel = SLTU;
            3'b100: arithSel = XOR;
            3'b101: arithSel = bit30 ? SRA : SRL;
            3'b110: arithSel = OR;
            3'b111: arithSel = AND;
            default: arithSel = ADD;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  branchSel = SUB;
            F3_BNE:  branchSel = SUB;      // zero flag tells equal from not equal.
            F3_BLT:  branchSel = SLT;
            F3_BGE:  branchSel = SGE;
            F3_BLTU: branchSel = SLTU;
            F3_BGEU: branchSel = SGEU;
            default: branchSel = ADD;      // 010 and 011 are unused.
        endcase
    end

    always_comb begin
        case (opcode)
            `OP_RTYPE:  aluSel = arithSel;
            `OP_IMM:    aluSel = (funct3 == 3'b000) ? ADD : arithSel;  // no subi.
            `OP_BRANCH: aluSel = branchSel;
            `OP_LOAD,
            `OP_STORE,
            `OP_LUI,
            `OP_AUIPC,
            `OP_JAL,
            `OP_JALR:   aluSel = ADD;      // address or pc arithmetic.
            default:    aluSel = ADD;
        endcase
    end

endmodule

//--- src/aluCore.sv
`timescale 1ns/1ps

module aluCore (
    input  aluExecPkg::aluSelT aluSel,
    input  aluExecPkg::wordT   operandA,
    input  aluExecPkg::wordT   operandB,
    output aluExecPkg::wordT   result,
    output logic               zero
);
    import aluExecPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = operandB[4:0];     // rv32 only uses five bits.
    assign ltSigned   = $signed(operandA) < $signed(operandB);
    assign ltUnsigned = operandA < operandB;

    always_comb begin
        case (aluSel)
            ADD:  result = operandA + operandB;
            SUB:  result = operandA - operandB;
            SLL:  result = operandA << shamt;
            SLT:  result = wordT'(ltSigned);
            SLTU: result = wordT'(ltUnsigned);
            XOR:  result = operandA ^ operandB;
            SRL:  result = operandA >> shamt;
            SRA:  result = wordT'($signed(operandA) >>> shamt);
            OR:   result = operandA | operandB;
            AND:  result = operandA & operandB;
            SGE:  result = wordT'(!ltSigned);
            SGEU: result = wordT'(!ltUnsigned);
            default: result = operandA + operandB;  // spare encodings.
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- src/execLane.sv
`timescale 1ns/1ps

module execLane (
    input  logic              clk,
    input  logic              rstN,
    input  logic              load,
    input  logic              releaseLane,
    input  rvIsaPkg::instrT   instr,
    input  aluExecPkg::wordT  operandA,
    input  aluExecPkg::wordT  operandB,
    output logic              busy,
    output logic              done,
    output aluExecPkg::wordT  result,
    output logic              zero
);
    import rvIsaPkg::*;
    import aluExecPkg::*;

    opcodeT opcodeQ;
    funct3T funct3Q;
    logic   bit30Q;
    wordT   opAQ;
    wordT   opBQ;
    aluSelT aluSel;
    wordT   aluResult;
    logic   aluZero;

    aluControl uControl (
        .opcode (opcodeQ),
        .funct3 (funct3Q),
        .bit30  (bit30Q),
        .aluSel (aluSel)
    );

    aluCore uCore (
        .aluSel   (aluSel),
        .operandA (opAQ),
        .operandB (opBQ),
        .result   (aluResult),
        .zero     (aluZero)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (releaseLane) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (busy) begin
            done <= 1'b1;                  // result is latched on this edge.
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opcodeQ <= instr[6:0];
            funct3Q <= instr[14:12];
            bit30Q  <= instr[30];
            opAQ    <= operandA;
            opBQ    <= operandB;
        end
        if (busy && !done) begin
            result <= aluResult;
            zero   <= aluZero;
        end
    end

endmodule

//--- src/opDispatcher.sv
`timescale 1ns/1ps
`include "cluster_consts.svh"

module opDispatcher (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      inReq,
    output logic                      inAck,
    input  logic [`CLUSTER_LANES-1:0] laneBusy,
    output logic [`CLUSTER_LANES-1:0] laneLoad
);
    import aluExecPkg::*;

    dispStateT state;
    laneIdT    issuePtr;                   // next lane in round-robin order.

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            issuePtr <= '0;
            inAck    <= 1'b0;
            laneLoad <= '0;
        end else begin
            laneLoad <= '0;                // load is a single-cycle pulse.
            case (state)
                IDLE: begin
                    // stall here while the target lane still holds a result.
                    if (inReq && !laneBusy[issuePtr]) begin
                        laneLoad[issuePtr] <= 1'b1;
                        inAck              <= 1'b1;
                        issuePtr           <= issuePtr + 1'b1;
                        state              <= ACKING;
                    end
                end
                ACKING: begin
                    if (!inReq) begin
                        inAck <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    state <= IDLE;         // return-to-zero turnaround.
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/resultCollector.sv
`timescale 1ns/1ps
`include "cluster_consts.svh"

module resultCollector (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`CLUSTER_LANES-1:0] laneDone,
    input  aluExecPkg::wordT          laneResult [`CLUSTER_LANES],
    input  logic [`CLUSTER_LANES-1:0] laneZero,
    output logic [`CLUSTER_LANES-1:0] laneRelease,
    output logic                      outReq,
    input  logic                      outAck,
    output aluExecPkg::wordT          outResult,
    output logic                      outZero
);
    import aluExecPkg::*;

    collStateT state;
    laneIdT    retirePtr;                  // follows the issue pointer.

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= WAIT;
            retirePtr   <= '0;
            outReq      <= 1'b0;
            laneRelease <= '0;
        end else begin
            laneRelease <= '0;
            case (state)
                WAIT: begin
                    if (laneDone[retirePtr]) begin
                        outReq <= 1'b1;
                        state  <= OFFER;
                    end
                end
                OFFER: begin
                    if (outAck) begin
                        outReq                 <= 1'b0;
                        laneRelease[retirePtr] <= 1'b1;
                        retirePtr              <= retirePtr + 1'b1;
                        state                  <= RETIRE;
                    end
                end
                RETIRE: begin
                    if (!outAck) state <= WAIT;  // consumer finished its half.
                end
                default: state <= WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT && laneDone[retirePtr]) begin
            outResult <= laneResult[retirePtr];
            outZero   <= laneZero[retirePtr];
        end
    end

endmodule

//--- src/aluCluster.sv
`timescale 1ns/1ps
`include "cluster_consts.svh"

module aluCluster (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inReq,
    output logic             inAck,
    input  rvIsaPkg::instrT  instr,
    input  aluExecPkg::wordT operandA,
    input  aluExecPkg::wordT operandB,
    output logic             outReq,
    input  logic             outAck,
    output aluExecPkg::wordT outResult,
    output logic             outZero
);
    import aluExecPkg::*;

    logic [`CLUSTER_LANES-1:0] laneBusy;
    logic [`CLUSTER_LANES-1:0] laneLoad;
    logic [`CLUSTER_LANES-1:0] laneDone;
    logic [`CLUSTER_LANES-1:0] laneZero;
    logic [`CLUSTER_LANES-1:0] laneRelease;
    wordT                      laneResult [`CLUSTER_LANES];

    opDispatcher uDispatcher (
        .clk      (clk),
        .rstN     (rstN),
        .inReq    (inReq),
        .inAck    (inAck),
        .laneBusy (laneBusy),
        .laneLoad (laneLoad)
    );

    // operands are broadcast, only the pulsed lane captures them.
    for (genvar i = 0; i < `CLUSTER_LANES; i++) begin : gLane
        execLane uLane (
            .clk         (clk),
            .rstN        (rstN),
            .load        (laneLoad[i]),
            .releaseLane (laneRelease[i]),
            .instr       (instr),
            .operandA    (operandA),
            .operandB    (operandB),
            .busy        (laneBusy[i]),
            .done        (laneDone[i]),
            .result      (laneResult[i]),
            .zero        (laneZero[i])
        );
    end

    resultCollector uCollector (
        .clk         (clk),
        .rstN        (rstN),
        .laneDone    (laneDone),
        .laneResult  (laneResult),
        .laneZero    (laneZero),
        .laneRelease (laneRelease),
        .outReq      (outReq),
        .outAck      (outAck),
        .outResult   (outResult),
        .outZero     (outZero)
    );

endmodule

//--- tb/aluCluster_checker.sv
`timescale 1ns/1ps

module aluCluster_checker (
    input logic             clk,
    input logic             rstN,
    input logic             inReq,
    input logic             inAck,
    input logic             outReq,
    input logic             outAck,
    input aluExecPkg::wordT outResult,
    input logic             outZero
);
    import aluExecPkg::*;

    int assertFails = 0;                   // read by the testbench at the end.

    ackFollowsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inAck) |-> inReq)
        else begin
            assertFails++;
            $error("inAck rose while inReq was low");
        end

    reqHoldsForAck: assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> outReq)
        else begin
            assertFails++;
            $error("outReq dropped before outAck");
        end

    // data must not move under a pending offer.
    offerStable: assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> $stable(outResult) && $stable(outZero))
        else begin
            assertFails++;
            $error("outResult or outZero changed during an offer");
        end

    quietInReset: assert property (@(posedge clk) !rstN |-> !outReq)
        else begin
            assertFails++;
            $error("outReq high during reset");
        end

endmodule

bind aluCluster aluCluster_checker uChecker (.*);

//--- tb/aluCluster_tb.sv
`timescale 1ns/1ps
`include "cluster_consts.svh"

module aluCluster_tb;
    import rvIsaPkg::*;
    import aluExecPkg::*;

    localparam int NUM_DIRECTED = 14;
    localparam int NUM_OPS      = NUM_DIRECTED + 200;
    localparam int TIMEOUT      = 200;

    // columns are instr, operandA, operandB, expected result.
    localparam logic [127:0] directed [NUM_DIRECTED] = '{
        {32'h0000_0033, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c},
        {32'h4000_0033, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe},  // sub.
        {32'h0000_1033, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000},
        {32'h4000_5033, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000},  // sra.
        {32'h0000_5033, 32'h8000_0000, 32'h0000_0024, 32'h0800_0000},  // only low 5 bits shift.
        {32'h0000_2033, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001},
        {32'h0000_3033, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000},
        {32'h4000_0013, 32'h0000_0010, 32'h0000_0003, 32'h0000_0013},  // addi ignores bit 30.
        {32'h0000_2003, 32'h0000_1000, 32'h0000_0008, 32'h0000_1008},
        {32'h0000_0063, 32'h0000_0009, 32'h0000_0009, 32'h0000_0000},  // beq, equal.
        {32'h0000_5063, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0001},
        {32'h0000_7063, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000},
        {32'h0000_2063, 32'h0000_0002, 32'h0000_0003, 32'h0000_0005},  // unused branch code.
        {32'h0000_007f, 32'h0000_0001, 32'h0000_0001, 32'h0000_0002}
    };

    localparam logic [6:0] opcodePool [8] = '{`OP_RTYPE, `OP_IMM, `OP_BRANCH, `OP_LOAD,
                                              `OP_STORE, `OP_LUI, `OP_JAL, 7'h7f};

    logic        clk = 1'b0;
    logic        rstN;
    logic        inReq;
    logic        inAck;
    instrT       instr;
    wordT        operandA;
    wordT        operandB;
    logic        outReq;
    logic        outAck;
    wordT        outResult;
    logic        outZero;
    logic [31:0] lfsr = 32'h966c_8442;
    instrT       stimInstr [NUM_OPS];
    wordT        stimA [NUM_OPS];
    wordT        stimB [NUM_OPS];
    int          ackDelay [NUM_OPS];
    wordT        expQueue [$];

    aluCluster dut (.*);

    always #4 clk = ~clk;

    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[30:0], lfsrBit()};
        return v;
    endfunction

    // expected value straight from the RV32I decode rules.
    function automatic wordT refResult(instrT ins, wordT a, wordT b);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [4:0] sh;
        opc = ins[6:0];
        f3  = ins[14:12];
        sh  = b[4:0];
        if (opc == `OP_BRANCH) begin
            case (f3)
                3'b000, 3'b001: return a - b;
                3'b100: return {31'b0, $signed(a) < $signed(b)};
                3'b101: return {31'b0, $signed(a) >= $signed(b)};
                3'b110: return {31'b0, a < b};
                3'b111: return {31'b0, a >= b};
                default: return a + b;
            endcase
        end
        if (opc != `OP_RTYPE && opc != `OP_IMM) return a + b;
        case (f3)
            3'b000: return (ins[30] && opc == `OP_RTYPE) ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (ins[30]) return $signed(a) >>> sh;
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareWord(string name, wordT actual, wordT expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    task automatic compareFlag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
            abortRun();
        end
    endtask

    task automatic waitInAck(logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (inAck !== level && cycles <= TIMEOUT);
        if (inAck !== level) begin
            $display("Timeout at %0t: inAck never went to %b", $time, level);
            abortRun();
        end
    endtask

    task automatic waitOutReq(logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (outReq !== level && cycles <= TIMEOUT);
        if (outReq !== level) begin
            $display("Timeout at %0t: outReq never went to %b", $time, level);
            abortRun();
        end
    endtask

    task automatic runProducer();
        for (int i = 0; i < NUM_OPS; i++) begin
            instr    <= stimInstr[i];
            operandA <= stimA[i];
            operandB <= stimB[i];
            inReq    <= 1'b1;
            waitInAck(1'b1);
            inReq <= 1'b0;
            waitInAck(1'b0);
        end
    endtask

    task automatic runConsumer();
        wordT expected;
        for (int i = 0; i < NUM_OPS; i++) begin
            waitOutReq(1'b1);
            expected = expQueue.pop_front();
            compareWord("outResult", outResult, expected);
            compareFlag("outZero", outZero, expected == '0);
            repeat (ackDelay[i]) @(posedge clk);
            outAck <= 1'b1;
            waitOutReq(1'b0);
            outAck <= 1'b0;
        end
    endtask

    initial begin
        rstN     = 1'b0;
        inReq    = 1'b0;
        outAck   = 1'b0;
        instr    = '0;
        operandA = '0;
        operandB = '0;
        for (int i = 0; i < NUM_DIRECTED; i++) begin
            stimInstr[i] = directed[i][127:96];
            stimA[i]     = directed[i][95:64];
            stimB[i]     = directed[i][63:32];
            compareWord("refResult", refResult(stimInstr[i], stimA[i], stimB[i]),
                        directed[i][31:0]);
            expQueue.push_back(directed[i][31:0]);
        end
        for (int i = NUM_DIRECTED; i < NUM_OPS; i++) begin
            stimInstr[i]        = '0;
            stimInstr[i][6:0]   = opcodePool[3'(randBits(3))];
            stimInstr[i][14:12] = 3'(randBits(3));
            stimInstr[i][30]    = 1'(randBits(1));
            stimA[i]            = randBits(32);
            stimB[i]            = (randBits(2) == 0) ? stimA[i] : randBits(32);  // some equal pairs.
            expQueue.push_back(refResult(stimInstr[i], stimA[i], stimB[i]));
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            ackDelay[i] = randBits(2);
            if (randBits(3) == 0) ackDelay[i] = 24;  // long stall fills every lane.
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);
        compareFlag("inAck", inAck, 1'b0);
        compareFlag("outReq", outReq, 1'b0);
        fork
            runProducer();
            runConsumer();
        join
        repeat (10) begin
            @(posedge clk);
            compareFlag("outReq", outReq, 1'b0);
        end
        if (dut.uChecker.assertFails == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Handshake assertions failed");
            abortRun();
        end
    end

endmodule

//--- flist.f
+incdir+src
src/rvIsaPkg.sv
src/aluExecPkg.sv
src/aluControl.sv
src/aluCore.sv
src/execLane.sv
src/opDispatcher.sv
src/resultCollector.sv
src/aluCluster.sv
tb/aluCluster_checker.sv
tb/aluCluster_tb.sv

//--- Bender.yml
package:
  name: alu_cluster

sources:
  - include_dirs:
      - src
    files:
      - src/rvIsaPkg.sv
      - src/aluExecPkg.sv
      - src/aluControl.sv
      - src/aluCore.sv
      - src/execLane.sv
      - src/opDispatcher.sv
      - src/resultCollector.sv
      - src/aluCluster.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/aluCluster_checker.sv
      - tb/aluCluster_tb.sv
